/* pkt_capture_top.f */
+incdir+hw
+incdir+sim
hw/pkt_pkg.sv
hw/pkt_snooper.sv
hw/pkt_width_adapter.sv
hw/pkt_mem.sv
hw/pkt_capture_top.sv
sim/pkt_capture_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = pkt_capture_tb
FILELIST  = pkt_capture_top.f
PASS_MSG  = all tests passed

.PHONY: sim clean

# Build and run, then decide pass or fail from the printed output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* sim/pkt_capture_tests.svh */
// Outputs straight after reset
task automatic check_reset_state();
   tests_run++;
   if (pkt_ready !== 1'b0)
      report_mismatch("reset_state", "pkt_ready", 64'd0, 64'(pkt_ready));
   if (drop_count !== 8'd0)
      report_mismatch("reset_state", "drop_count", 64'd0, 64'(drop_count));
endtask

// Four full words fill two wide words exactly
task automatic capture_even_packet();
   logic [63:0] data;
   tests_run++;
   for (int i = 0; i < 4; i++)
      pkt_words[i] = $urandom();
   send_packet(4, 3'd4);
   wait_ready("even_packet");
   if (pkt_len !== 13'd16)
      report_mismatch("even_packet", "pkt_len", 64'd16, 64'(pkt_len));
   read_word(9'd0, data);
   if (data !== {pkt_words[0], pkt_words[1]})
      report_mismatch("even_packet", "word 0", {pkt_words[0], pkt_words[1]}, data);
   read_word(9'd1, data);
   if (data !== {pkt_words[2], pkt_words[3]})
      report_mismatch("even_packet", "word 1", {pkt_words[2], pkt_words[3]}, data);
   release_packet();
   if (pkt_ready !== 1'b0)
      report_mismatch("even_packet", "pkt_ready after ack", 64'd0, 64'(pkt_ready));
endtask

// Tail lands in the upper lane only, 4 + 4 + 2 bytes
task automatic capture_odd_packet();
   logic [63:0] data;
   tests_run++;
   for (int i = 0; i < 3; i++)
      pkt_words[i] = $urandom();
   send_packet(3, 3'd2);
   wait_ready("odd_packet");
   if (pkt_len !== 13'd10)
      report_mismatch("odd_packet", "pkt_len", 64'd10, 64'(pkt_len));
   read_word(9'd1, data);
   if (data[63:32] !== pkt_words[2])
      report_mismatch("odd_packet", "word 1 upper", 64'(pkt_words[2]), 64'(data[63:32]));
   release_packet();
endtask

task automatic drop_while_held();
   logic [63:0] data;
   logic [63:0] held_word;
   tests_run++;
   for (int i = 0; i < 2; i++)
      pkt_words[i] = $urandom();
   send_packet(2, 3'd4);
   wait_ready("drop_held");
   if (pkt_len !== 13'd8)
      report_mismatch("drop_held", "held pkt_len", 64'd8, 64'(pkt_len));
   held_word = {pkt_words[0], pkt_words[1]};

   // Second packet arrives before the first is acknowledged
   for (int i = 0; i < 3; i++)
      pkt_words[i] = $urandom();
   send_packet(3, 3'd4);
   next_cycle();
   if (drop_count !== 8'd1)
      report_mismatch("drop_held", "drop_count", 64'd1, 64'(drop_count));
   if (pkt_len !== 13'd8)
      report_mismatch("drop_held", "pkt_len", 64'd8, 64'(pkt_len));
   read_word(9'd0, data);
   if (data !== held_word)
      report_mismatch("drop_held", "word 0", held_word, data);
   release_packet();

   // Capture resumes once released
   for (int i = 0; i < 3; i++)
      pkt_words[i] = $urandom();
   send_packet(3, 3'd1);
   wait_ready("drop_held");
   if (pkt_len !== 13'd9)
      report_mismatch("drop_held", "third pkt_len", 64'd9, 64'(pkt_len));
   read_word(9'd0, data);
   if (data !== {pkt_words[0], pkt_words[1]})
      report_mismatch("drop_held", "third word 0", {pkt_words[0], pkt_words[1]}, data);
   release_packet();
endtask

// Only the first 1024 words fit, 4 bytes each
task automatic truncate_long_packet();
   logic [63:0] data;
   tests_run++;
   for (int i = 0; i < MAX_WORDS; i++)
      pkt_words[i] = $urandom();
   send_packet(MAX_WORDS, 3'd4);
   wait_ready("truncation");
   if (pkt_len !== 13'd4096)
      report_mismatch("truncation", "pkt_len", 64'd4096, 64'(pkt_len));
   read_word(9'd511, data);
   if (data !== {pkt_words[1022], pkt_words[1023]})
      report_mismatch("truncation", "word 511", {pkt_words[1022], pkt_words[1023]}, data);
   // Words past the end must not wrap onto the start
   read_word(9'd0, data);
   if (data !== {pkt_words[0], pkt_words[1]})
      report_mismatch("truncation", "word 0", {pkt_words[0], pkt_words[1]}, data);
   release_packet();
endtask

/* sim/pkt_capture_tb.sv */
`include "pkt_cfg.svh"

module pkt_capture_tb;

   localparam int TIMEOUT_CYCLES = 5000;
   localparam int MAX_WORDS      = 1030;

   logic                           clk;
   logic                           rst;
   logic [`PKT_IN_WIDTH-1:0]       word;
   logic                           word_valid;
   logic                           word_last;
   logic [`PKT_IN_CNT_WIDTH-1:0]   word_bytes;
   logic                           pkt_ack;
   logic [`PKT_OUT_ADDR_WIDTH-1:0] rd_addr;
   logic [`PKT_OUT_WIDTH-1:0]      rd_data;
   logic                           pkt_ready;
   logic [`PKT_LEN_WIDTH-1:0]      pkt_len;
   logic [7:0]                     drop_count;

   int errors;
   int tests_run;

   // Payload of the packet about to be sent
   logic [`PKT_IN_WIDTH-1:0] pkt_words [MAX_WORDS];

   pkt_capture_top pkt_capture_top_inst (
      .clk        (clk),
      .rst        (rst),
      .word       (word),
      .word_valid (word_valid),
      .word_last  (word_last),
      .word_bytes (word_bytes),
      .pkt_ack    (pkt_ack),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .pkt_ready  (pkt_ready),
      .pkt_len    (pkt_len),
      .drop_count (drop_count)
   );

   always #10 clk = ~clk;

   // Inputs change a little after each rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic report_mismatch(input string test, input string what,
                                  input logic [63:0] expected, input logic [63:0] actual);
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test, what, expected, actual);
   endtask

   // One word per cycle, full words except possibly the last
   task automatic send_packet(input int n, input logic [`PKT_IN_CNT_WIDTH-1:0] last_bytes);
      for (int i = 0; i < n; i++) begin
         word       = pkt_words[i];
         word_valid = 1'b1;
         word_last  = (i == n - 1);
         word_bytes = (i == n - 1) ? last_bytes : 3'd4;
         next_cycle();
      end
      word_valid = 1'b0;
      word_last  = 1'b0;
      word_bytes = '0;
   endtask

   task automatic wait_ready(input string test);
      int cycles;
      cycles = 0;
      while (!pkt_ready && cycles < TIMEOUT_CYCLES) begin
         next_cycle();
         cycles++;
      end
      if (!pkt_ready) begin
         errors++;
         $display("%s: pkt_ready did not rise within %0d cycles", test, TIMEOUT_CYCLES);
      end
   endtask

   // Registered read port, data one cycle after the address
   task automatic read_word(input logic [`PKT_OUT_ADDR_WIDTH-1:0] addr,
                            output logic [`PKT_OUT_WIDTH-1:0] data);
      rd_addr = addr;
      next_cycle();
      data = rd_data;
   endtask

   task automatic release_packet();
      pkt_ack = 1'b1;
      next_cycle();
      pkt_ack = 1'b0;
   endtask

   `include "pkt_capture_tests.svh"

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      word       = '0;
      word_valid = 1'b0;
      word_last  = 1'b0;
      word_bytes = '0;
      pkt_ack    = 1'b0;
      rd_addr    = '0;
      errors     = 0;
      tests_run  = 0;
      void'($urandom(32'he979));

      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;

      check_reset_state();
      capture_even_packet();
      capture_odd_packet();
      drop_while_held();
      truncate_long_packet();

      $display("tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* hw/pkt_capture_top.sv */
`include "pkt_cfg.svh"

module pkt_capture_top
   import pkt_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic [`PKT_IN_WIDTH-1:0]       word,
   input  logic                           word_valid,
   input  logic                           word_last,
   input  logic [`PKT_IN_CNT_WIDTH-1:0]   word_bytes,
   input  logic                           pkt_ack,
   input  logic [`PKT_OUT_ADDR_WIDTH-1:0] rd_addr,
   output logic [`PKT_OUT_WIDTH-1:0]      rd_data,
   output logic                           pkt_ready,
   output logic [`PKT_LEN_WIDTH-1:0]      pkt_len,
   output logic [7:0]                     drop_count
);

   narrow_wr_t nwr;
   wide_wr_t   wwr;

   pkt_snooper pkt_snooper_inst (
      .clk        (clk),
      .rst        (rst),
      .word       (word),
      .word_valid (word_valid),
      .word_last  (word_last),
      .word_bytes (word_bytes),
      .pkt_ack    (pkt_ack),
      .nwr        (nwr),
      .drop_count (drop_count)
   );

   pkt_width_adapter pkt_width_adapter_inst (
      .clk (clk),
      .rst (rst),
      .nwr (nwr),
      .wwr (wwr)
   );

   pkt_mem pkt_mem_inst (
      .clk       (clk),
      .rst       (rst),
      .wwr       (wwr),
      .pkt_ack   (pkt_ack),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .pkt_ready (pkt_ready),
      .pkt_len   (pkt_len)
   );

endmodule

/* hw/pkt_mem.sv */
`include "pkt_cfg.svh"

module pkt_mem
   import pkt_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst,
   input  wide_wr_t                       wwr,
   input  logic                           pkt_ack,
   input  logic [`PKT_OUT_ADDR_WIDTH-1:0] rd_addr,
   output logic [`PKT_OUT_WIDTH-1:0]      rd_data,
   output logic                           pkt_ready,
   output logic [`PKT_LEN_WIDTH-1:0]      pkt_len
);

   logic [`PKT_OUT_WIDTH-1:0] mem [1 << `PKT_OUT_ADDR_WIDTH];
   logic [`PKT_LEN_WIDTH-1:0] len_acc;
   logic [`PKT_LEN_WIDTH-1:0] wr_cnt;

   // Bytes contributed by this cycle's wide write
   assign wr_cnt = wwr.wr_en ?
                   {{(`PKT_LEN_WIDTH-`PKT_OUT_CNT_WIDTH){1'b0}}, wwr.byte_cnt} : '0;

   always_ff @(posedge clk) begin
      if (wwr.wr_en)
         mem[wwr.addr] <= wwr.data;
      rd_data <= mem[rd_addr];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         len_acc   <= '0;
         pkt_ready <= 1'b0;
         pkt_len   <= '0;
      end else if (wwr.done) begin
         // Include the count of a final write in the same cycle
         pkt_len   <= len_acc + wr_cnt;
         len_acc   <= '0;
         pkt_ready <= 1'b1;
      end else begin
         len_acc <= len_acc + wr_cnt;
         if (pkt_ack)
            pkt_ready <= 1'b0;
      end
   end

endmodule

/* hw/pkt_width_adapter.sv */
`include "pkt_cfg.svh"

module pkt_width_adapter
   import pkt_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  narrow_wr_t nwr,
   output wide_wr_t   wwr
);

   // Lane 1 is bits 63:32, filled from even narrow addresses
   logic [`PKT_IN_WIDTH-1:0]      lane_q   [2];
   logic [`PKT_IN_WIDTH-1:0]      lane_nxt [2];
   logic                          lane_sel;
   logic [`PKT_OUT_CNT_WIDTH-1:0] acc_q;
   logic [`PKT_OUT_CNT_WIDTH-1:0] cnt_ext;

   assign lane_sel = ~nwr.addr[0];
   assign cnt_ext  = {{(`PKT_OUT_CNT_WIDTH-`PKT_IN_CNT_WIDTH){1'b0}}, nwr.byte_cnt};

   // New data bypasses its lane so the wide write sees it at once
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         if (nwr.wr_en && lane_sel == i[0])
            lane_nxt[i] = nwr.data;
         else
            lane_nxt[i] = lane_q[i];
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 2; i++) begin
         if (rst)
            lane_q[i] <= '0;
         else
            lane_q[i] <= lane_nxt[i];
      end
   end

   // Bytes gathered so far in the wide word under construction
   always_ff @(posedge clk) begin
      if (rst || wwr.wr_en)
         acc_q <= '0;
      else if (nwr.wr_en)
         acc_q <= acc_q + cnt_ext;
   end

   always_comb begin
      wwr.addr     = nwr.addr[`PKT_IN_ADDR_WIDTH-1:1];
      wwr.data     = {lane_nxt[1], lane_nxt[0]};
      // Flush on the lower lane or when the packet ends on an upper lane
      wwr.wr_en    = nwr.wr_en && (nwr.addr[0] || nwr.done);
      wwr.byte_cnt = acc_q + cnt_ext;
      wwr.done     = nwr.done;
   end

endmodule

/* hw/pkt_snooper.sv */
`include "pkt_cfg.svh"

module pkt_snooper
   import pkt_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`PKT_IN_WIDTH-1:0]     word,
   input  logic                         word_valid,
   input  logic                         word_last,
   input  logic [`PKT_IN_CNT_WIDTH-1:0] word_bytes,
   input  logic                         pkt_ack,
   output narrow_wr_t                   nwr,
   output logic [7:0]                   drop_count
);

   snoop_state_t                  state;
   logic [`PKT_IN_ADDR_WIDTH-1:0] wr_addr;
   logic                          sat;
   logic                          release_q;
   logic                          take;
   logic                          pkt_end;

   logic                          wr_en_q;
   logic                          done_q;
   logic [`PKT_IN_ADDR_WIDTH-1:0] addr_q;
   logic [`PKT_IN_WIDTH-1:0]      data_q;
   logic [`PKT_IN_CNT_WIDTH-1:0]  cnt_q;

   // Words are written only while capturing and below the memory end
   assign take    = word_valid && (state == IDLE || (state == CAPTURE && !sat));
   assign pkt_end = word_valid && word_last && (state == IDLE || state == CAPTURE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         wr_addr    <= '0;
         sat        <= 1'b0;
         release_q  <= 1'b0;
         wr_en_q    <= 1'b0;
         done_q     <= 1'b0;
         drop_count <= '0;
      end else begin
         wr_en_q <= take;
         done_q  <= pkt_end;

         // Address restarts at zero for the next captured packet
         if (pkt_end) begin
            wr_addr <= '0;
            sat     <= 1'b0;
         end else if (take) begin
            wr_addr <= wr_addr + 1'b1;
            if (&wr_addr)
               sat <= 1'b1;
         end

         case (state)
            IDLE: begin
               if (word_valid)
                  state <= word_last ? HOLD : CAPTURE;
            end
            CAPTURE: begin
               if (word_valid && word_last)
                  state <= HOLD;
            end
            HOLD: begin
               if (word_valid && word_last) begin
                  drop_count <= drop_count + 1'b1;
                  state      <= pkt_ack ? IDLE : HOLD;
               end else if (word_valid) begin
                  // Remember a release that lands mid-drop
                  release_q <= pkt_ack;
                  state     <= DROP;
               end else if (pkt_ack) begin
                  state <= IDLE;
               end
            end
            DROP: begin
               if (word_valid && word_last) begin
                  drop_count <= drop_count + 1'b1;
                  release_q  <= 1'b0;
                  state      <= (release_q || pkt_ack) ? IDLE : HOLD;
               end else if (pkt_ack) begin
                  release_q <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Payload, byte count is zero on a bare done
   always_ff @(posedge clk) begin
      cnt_q <= take ? word_bytes : '0;
      if (take) begin
         addr_q <= wr_addr;
         data_q <= word;
      end
   end

   assign nwr = '{addr: addr_q, data: data_q, wr_en: wr_en_q, byte_cnt: cnt_q, done: done_q};

endmodule

/* hw/pkt_pkg.sv */
`include "pkt_cfg.svh"

package pkt_pkg;

   // Snooper to width adapter
   typedef struct packed {
      logic [`PKT_IN_ADDR_WIDTH-1:0] addr;
      logic [`PKT_IN_WIDTH-1:0]      data;
      logic                          wr_en;
      logic [`PKT_IN_CNT_WIDTH-1:0]  byte_cnt;
      logic                          done;
   } narrow_wr_t;

   // Width adapter to packet memory
   typedef struct packed {
      logic [`PKT_OUT_ADDR_WIDTH-1:0] addr;
      logic [`PKT_OUT_WIDTH-1:0]      data;
      logic                           wr_en;
      logic [`PKT_OUT_CNT_WIDTH-1:0]  byte_cnt;
      logic                           done;
   } wide_wr_t;

   typedef enum logic [1:0] {
      IDLE,
      CAPTURE,
      DROP,
      HOLD
   } snoop_state_t;

endpackage

/* hw/pkt_cfg.svh */
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

// Snooper side, one 32-bit word per narrow write
`define PKT_IN_WIDTH 32

// Packet memory side, two narrow words per entry
`define PKT_OUT_WIDTH 64

// Narrow word address covers 1024 words
`define PKT_IN_ADDR_WIDTH 10

// Wide address drops the lane select bit
`define PKT_OUT_ADDR_WIDTH 9

// 0 to 4 bytes per narrow word
`define PKT_IN_CNT_WIDTH 3

// 0 to 8 bytes per wide word
`define PKT_OUT_CNT_WIDTH 4

// Up to 4096 bytes in one held packet
`define PKT_LEN_WIDTH 13

`endif
